// ==== compile.f ====
+incdir+.
uart_frame_pkg.sv
uart_cmd_pkg.sv
uart_cmd_dispatch.sv
uart_cmd_channel.sv
uart_read_collect.sv
uart_cmd_hub.sv
tb_uart_line_model.sv
tb_uart_cmd_hub.sv

// ==== Makefile ====
# Verilator flow for the UART command hub

VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= tb_uart_cmd_hub
RTL_TOP   ?= uart_cmd_hub
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(wildcard *.sv *.svh) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_uart_cmd_hub.sv ====
`timescale 1ns/1ps
`include "uart_cmd_config.svh"

module tb_uart_cmd_hub;

  localparam int NCH      = `UART_NUM_CHAN;
  localparam int NUM_CMDS = 63;

  logic                    clk;
  logic                    rst_n;
  uart_cmd_pkg::cmd_word_u cmd_in;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  logic [NCH-1:0]          tx;
  logic [NCH-1:0]          rx;
  logic [7:0]              read_data;
  uart_cmd_pkg::chan_id_t  read_chan;
  logic                    read_err;
  logic                    read_rdy;

  logic [1:0]     fault [NCH];
  logic [NCH-1:0] frame_seen;
  logic [7:0]     frame_byte [NCH];
  logic [NCH-1:0] frame_ok;

  logic [7:0]  shadow [NCH][32];
  logic [7:0]  frame_q [NCH][$];  // Expected tx bytes per channel
  logic [10:0] resp_q [$];        // Outstanding reads as {chan, err, data}
  integer      seed;
  string       test_name;

  uart_cmd_hub u_uart_cmd_hub (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_data (read_data),
    .read_chan (read_chan),
    .read_err  (read_err),
    .read_rdy  (read_rdy)
  );

  for (genvar c = 0; c < NCH; c++)
  begin : g_model
    tb_uart_line_model #(.CHAN(c)) u_model (
      .clk        (clk),
      .tx         (tx[c]),
      .rx         (rx[c]),
      .fault      (fault[c]),
      .frame_seen (frame_seen[c]),
      .frame_byte (frame_byte[c]),
      .frame_ok   (frame_ok[c])
    );
  end

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s read_data expected %02h actual %02h", test_name, exp, act));
  endtask

  task automatic check_chan(input uart_cmd_pkg::chan_id_t exp, input uart_cmd_pkg::chan_id_t act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s read_chan expected %0d actual %0d", test_name, exp, act));
  endtask

  task automatic check_err(input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s read_err expected %0b actual %0b", test_name, exp, act));
  endtask

  task automatic check_frame(input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      fail_run($sformatf("MISMATCH %s tx frame expected %02h actual %02h", test_name, exp, act));
  endtask

  // Expected read result from the write shadow and the injected fault
  function automatic logic [10:0] ref_read(input uart_cmd_pkg::chan_id_t ch,
                                           input logic [4:0] ra, input logic [1:0] f);
    logic [7:0] d;
    logic       e;
    d = shadow[ch][ra];
    e = (f != 2'd0);
    if (f == 2'd3)
      d = '0;  // Silent device
    return {ch, e, d};
  endfunction

  // Called on a falling edge and returns on the falling edge after acceptance
  task automatic send_cmd(input uart_cmd_pkg::rw_e op, input uart_cmd_pkg::chan_id_t ch,
                          input logic [4:0] ra, input logic [7:0] d);
    uart_cmd_pkg::cmd_word_u w;
    w.wr.op       = op;
    w.wr.chan     = ch;
    w.wr.reg_addr = ra;
    w.wr.data     = d;
    cmd_in  = w;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
      @(negedge clk);
    @(negedge clk);
    cmd_vld = 1'b0;
    frame_q[ch].push_back({op, ch, ra});
    if (op == uart_cmd_pkg::RW_WRITE)
    begin
      frame_q[ch].push_back(d);
      shadow[ch][ra] = d;
    end
    else
      resp_q.push_back(ref_read(ch, ra, fault[ch]));
  endtask

  function automatic bit pending();
    bit p;
    p = resp_q.size() != 0;
    for (int c = 0; c < NCH; c++)
      p = p || frame_q[c].size() != 0;
    return p;
  endfunction

  task automatic wait_idle();
    while (pending())
      @(negedge clk);
    repeat (4 * `UART_BAUD_DIV) @(negedge clk);  // Last stop bit ends
  endtask

  // --------------------------------------------------
  // Comparing process
  // --------------------------------------------------
  always @(negedge clk)
  begin : compare
    int          idx;
    logic [10:0] e;
    if (rst_n)
    begin
      for (int c = 0; c < NCH; c++)
      begin
        if (frame_seen[c])
        begin
          if (!frame_ok[c])
            fail_run($sformatf("Channel %0d sent a frame with bad parity or stop bit", c));
          if (frame_q[c].size() == 0)
            fail_run($sformatf("Channel %0d sent a frame that no command asked for", c));
          check_frame(frame_q[c].pop_front(), frame_byte[c]);
        end
      end
      if (read_rdy)
      begin
        if (resp_q.size() == 0)
          fail_run("read_rdy pulsed with no read outstanding");
        idx = -1;
        foreach (resp_q[i])
          if (idx < 0 && resp_q[i][10:9] == read_chan)
            idx = i;
        if (idx < 0)
          idx = 0;  // Oldest outstanding read when no channel matches
        e = resp_q[idx];
        resp_q.delete(idx);
        check_chan(e[10:9], read_chan);
        check_err(e[8], read_err);
        check_data(e[7:0], read_data);
      end
    end
  end

  initial
  begin
    #(64'(NUM_CMDS) * 40 * `UART_BAUD_DIV * 8 + 200000);
    fail_run("Watchdog expired before all commands completed");
  end

  initial
  begin
    uart_cmd_pkg::rw_e      op;
    uart_cmd_pkg::chan_id_t ch;
    seed    = 32'h3e6a;
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    for (int c = 0; c < NCH; c++)
    begin
      fault[c] = 2'd0;
      for (int r = 0; r < 32; r++)
        shadow[c][r] = 8'(((c * 32 + r) * 75) ^ 90);
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_name = "reset";
    if (cmd_rdy !== 1'b1 || read_rdy !== 1'b0 || tx !== '1)
      fail_run("Host or serial outputs hold wrong values after reset");

    test_name = "write_all";
    for (int c = 0; c < NCH; c++)
    begin
      send_cmd(uart_cmd_pkg::RW_WRITE, 2'(c), 5'd3, 8'($random(seed)));
      send_cmd(uart_cmd_pkg::RW_WRITE, 2'(c), 5'd17, 8'($random(seed)));
    end
    wait_idle();

    test_name = "read_back";
    for (int c = 0; c < NCH; c++)
    begin
      send_cmd(uart_cmd_pkg::RW_READ, 2'(c), 5'd3, 8'h00);
      send_cmd(uart_cmd_pkg::RW_READ, 2'(c), 5'd17, 8'h00);
    end
    wait_idle();

    test_name = "fault";
    for (int f = 1; f < 4; f++)
    begin
      fault[f] = 2'(f);
      send_cmd(uart_cmd_pkg::RW_READ, 2'(f), 5'd17, 8'h00);
      wait_idle();
      fault[f] = 2'd0;
    end

    test_name = "random_mix";
    for (int n = 0; n < 40; n++)
    begin
      op = uart_cmd_pkg::rw_e'($random(seed) & 1);
      ch = 2'($random(seed));
      send_cmd(op, ch, 5'($random(seed) & 3), 8'($random(seed)));
    end
    wait_idle();

    test_name = "parallel_reads";
    for (int c = 0; c < NCH; c++)
      send_cmd(uart_cmd_pkg::RW_READ, 2'(c), 5'd3, 8'h00);
    wait_idle();

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== tb_uart_line_model.sv ====
`timescale 1ns/1ps
`include "uart_cmd_config.svh"

module tb_uart_line_model #(
  parameter int CHAN = 0
) (
  input  logic       clk,
  input  logic       tx,
  output logic       rx,
  input  logic [1:0] fault,       // 0 none, 1 parity, 2 stop, 3 silent
  output logic       frame_seen,
  output logic [7:0] frame_byte,
  output logic       frame_ok
);

  localparam int BAUD = `UART_BAUD_DIV;

  logic [7:0] regs [32];
  integer     seed;

  // --------------------------------------------------
  // Response frame on rx
  // --------------------------------------------------
  task automatic send_byte(input logic [7:0] b, input logic [1:0] f);
    int delay;
    delay = 1 + ($unsigned($random(seed)) % 20);
    repeat (delay * BAUD) @(negedge clk);
    if (f != 2'd3)
    begin
      rx = 1'b0;
      repeat (BAUD) @(negedge clk);
      for (int k = 0; k < 8; k++)
      begin
        rx = b[k];  // LSB first
        repeat (BAUD) @(negedge clk);
      end
      rx = ~^b ^ (f == 2'd1);
      repeat (BAUD) @(negedge clk);
      rx = (f != 2'd2);
      repeat (BAUD) @(negedge clk);
      rx = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // Frame decoder on tx
  // --------------------------------------------------
  initial
  begin
    logic [7:0] b;
    logic       par;
    logic       ok;
    logic       want_data;
    logic [4:0] addr;
    seed       = 32'h3e6a + CHAN;
    rx         = 1'b1;
    frame_seen = 1'b0;
    frame_byte = '0;
    frame_ok   = 1'b0;
    want_data  = 1'b0;
    addr       = '0;
    for (int r = 0; r < 32; r++)
      regs[r] = 8'(((CHAN * 32 + r) * 75) ^ 90);
    forever
    begin
      @(negedge tx);
      repeat (BAUD / 2) @(posedge clk);
      ok = !tx;
      for (int k = 0; k < 8; k++)
      begin
        repeat (BAUD) @(posedge clk);
        b[k] = tx;
      end
      repeat (BAUD) @(posedge clk);
      par = tx;
      repeat (BAUD) @(posedge clk);
      ok = ok && tx && (^{par, b} == 1'b1);
      frame_byte <= b;
      frame_ok   <= ok;
      frame_seen <= 1'b1;
      if (want_data)
      begin
        regs[addr] = b;
        want_data  = 1'b0;
      end
      else if (b[7])
      begin
        want_data = 1'b1;  // Write, data frame follows
        addr      = b[4:0];
      end
      else
      begin
        fork
          send_byte(regs[b[4:0]], fault);
        join_none
      end
      @(posedge clk);
      frame_seen <= 1'b0;
    end
  end

endmodule

// ==== uart_cmd_hub.sv ====
`timescale 1ns/1ps
`include "uart_cmd_config.svh"

module uart_cmd_hub (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::cmd_word_u    cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic [`UART_NUM_CHAN-1:0]  tx,
  input  logic [`UART_NUM_CHAN-1:0]  rx,
  output logic [7:0]                 read_data,
  output uart_cmd_pkg::chan_id_t     read_chan,
  output logic                       read_err,
  output logic                       read_rdy
);

  uart_cmd_pkg::cmd_word_u                cmd;
  logic [`UART_NUM_CHAN-1:0]              start;
  logic [`UART_NUM_CHAN-1:0]              busy;
  logic [`UART_NUM_CHAN-1:0]              resp_vld;
  logic [`UART_NUM_CHAN-1:0][7:0]         resp_data;
  logic [`UART_NUM_CHAN-1:0]              resp_err;
  logic [`UART_NUM_CHAN-1:0]              ack;

  uart_cmd_dispatch u_dispatch (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .busy    (busy),
    .start   (start),
    .cmd     (cmd)
  );

  for (genvar i = 0; i < `UART_NUM_CHAN; i++)
  begin : g_chan
    uart_cmd_channel u_channel (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start[i]),
      .cmd       (cmd),
      .busy      (busy[i]),
      .tx        (tx[i]),
      .rx        (rx[i]),
      .resp_vld  (resp_vld[i]),
      .resp_data (resp_data[i]),
      .resp_err  (resp_err[i]),
      .ack       (ack[i])
    );
  end

  uart_read_collect u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .resp_vld  (resp_vld),
    .resp_data (resp_data),
    .resp_err  (resp_err),
    .ack       (ack),
    .read_data (read_data),
    .read_chan (read_chan),
    .read_err  (read_err),
    .read_rdy  (read_rdy)
  );

endmodule

// ==== uart_read_collect.sv ====
`timescale 1ns/1ps
`include "uart_cmd_config.svh"

module uart_read_collect (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [`UART_NUM_CHAN-1:0]       resp_vld,
  input  logic [`UART_NUM_CHAN-1:0][7:0]  resp_data,
  input  logic [`UART_NUM_CHAN-1:0]       resp_err,
  output logic [`UART_NUM_CHAN-1:0]       ack,
  output logic [7:0]                      read_data,
  output uart_cmd_pkg::chan_id_t          read_chan,
  output logic                            read_err,
  output logic                            read_rdy
);

  uart_cmd_pkg::chan_id_t            ptr;
  uart_cmd_pkg::chan_id_t            grant_idx;
  logic                              grant_vld;
  logic [`UART_NUM_CHAN-1:0]         req;

  assign req = resp_vld & ~ack;  // Acked channel still shows valid for one cycle

  always_comb
  begin
    uart_cmd_pkg::chan_id_t idx;
    grant_vld = 1'b0;
    grant_idx = ptr;
    for (int k = 0; k < `UART_NUM_CHAN; k++)
    begin
      idx = ptr + uart_cmd_pkg::chan_id_t'(k);
      if (!grant_vld && req[idx])
      begin
        grant_vld = 1'b1;
        grant_idx = idx;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ptr      <= '0;
      ack      <= '0;
      read_rdy <= 1'b0;
    end
    else
    begin
      ack      <= '0;
      read_rdy <= grant_vld;
      if (grant_vld)
      begin
        ack[grant_idx] <= 1'b1;
        ptr            <= grant_idx + 1'b1;  // Winner goes to the back
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (grant_vld)
    begin
      read_data <= resp_data[grant_idx];
      read_chan <= grant_idx;
      read_err  <= resp_err[grant_idx];
    end
  end

  a_ack_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(ack)
  );

endmodule

// ==== uart_cmd_channel.sv ====
`timescale 1ns/1ps
`include "uart_cmd_config.svh"

module uart_cmd_channel (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  uart_cmd_pkg::cmd_word_u cmd,
  output logic                    busy,
  output logic                    tx,
  input  logic                    rx,
  output logic                    resp_vld,
  output logic [7:0]              resp_data,
  output logic                    resp_err,
  input  logic                    ack
);

  localparam int BAUD_CW = $clog2(`UART_BAUD_DIV);
  localparam int BIT_CW  = $clog2(`UART_RESP_TIMEOUT_BITS + `UART_GAP_BITS + 8);

  localparam logic [BAUD_CW-1:0] BAUD_LAST = BAUD_CW'(`UART_BAUD_DIV - 1);
  localparam logic [BAUD_CW-1:0] BAUD_MID  = BAUD_CW'(`UART_BAUD_DIV / 2);
  localparam logic [BIT_CW-1:0]  DATA_LAST = BIT_CW'(7);
  localparam logic [BIT_CW-1:0]  GAP_LAST  = BIT_CW'(`UART_GAP_BITS - 1);
  localparam logic [BIT_CW-1:0]  TO_LAST   = BIT_CW'(`UART_RESP_TIMEOUT_BITS - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_GAP,
    ST_DATA,
    ST_HUNT,
    ST_RECV,
    ST_RESP
  } chan_state_e;

  chan_state_e                 state;
  uart_frame_pkg::line_phase_e phase;
  logic [BAUD_CW-1:0]          baud_cnt;
  logic [BIT_CW-1:0]           bit_cnt;
  logic                        bit_end;
  logic                        mid_bit;

  logic [7:0] tx_byte;
  logic [7:0] wr_data;
  logic       is_read;
  logic [7:0] rx_shift;
  logic       par_bad;
  logic       rx_meta;
  logic       rx_sync;

  logic gap_done;
  logic hunt_timeout;
  logic data_sample;
  logic parity_sample;
  logic stop_sample;

  assign bit_end  = baud_cnt == BAUD_LAST;
  assign mid_bit  = baud_cnt == BAUD_MID;
  assign busy     = state != ST_IDLE;
  assign resp_vld = state == ST_RESP;

  assign gap_done      = state == ST_GAP && bit_end && bit_cnt == GAP_LAST;
  assign hunt_timeout  = state == ST_HUNT && rx_sync && bit_end && bit_cnt == TO_LAST;
  assign data_sample   = state == ST_RECV && mid_bit && phase == uart_frame_pkg::LINE_DATA;
  assign parity_sample = state == ST_RECV && mid_bit && phase == uart_frame_pkg::LINE_PARITY;
  assign stop_sample   = state == ST_RECV && mid_bit && phase == uart_frame_pkg::LINE_STOP;

  // --------------------------------------------------
  // Sequencer and transmit line
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      phase    <= uart_frame_pkg::LINE_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            state    <= ST_ADDR;
            phase    <= uart_frame_pkg::LINE_START;
            baud_cnt <= '0;
            tx       <= 1'b0;
          end
        end
        ST_ADDR, ST_DATA:
        begin
          baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
          if (bit_end)
          begin
            case (phase)
              uart_frame_pkg::LINE_START:
              begin
                phase   <= uart_frame_pkg::LINE_DATA;
                bit_cnt <= '0;
                tx      <= tx_byte[0];  // LSB first
              end
              uart_frame_pkg::LINE_DATA:
              begin
                if (bit_cnt == DATA_LAST)
                begin
                  phase <= uart_frame_pkg::LINE_PARITY;
                  tx    <= uart_frame_pkg::frame_parity(tx_byte);
                end
                else
                begin
                  bit_cnt <= bit_cnt + 1'b1;
                  tx      <= tx_byte[bit_cnt[2:0] + 3'd1];
                end
              end
              uart_frame_pkg::LINE_PARITY:
              begin
                phase <= uart_frame_pkg::LINE_STOP;
                tx    <= 1'b1;
              end
              default:
              begin
                phase   <= uart_frame_pkg::LINE_IDLE;
                bit_cnt <= '0;
                if (state == ST_DATA)
                  state <= ST_IDLE;
                else if (is_read)
                  state <= ST_HUNT;
                else
                  state <= ST_GAP;
              end
            endcase
          end
        end
        ST_GAP:
        begin
          baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
          if (gap_done)
          begin
            state   <= ST_DATA;
            phase   <= uart_frame_pkg::LINE_START;
            bit_cnt <= '0;
            tx      <= 1'b0;
          end
          else if (bit_end)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ST_HUNT:
        begin
          if (!rx_sync)
          begin
            state    <= ST_RECV;  // Start edge, realign the bit timer
            phase    <= uart_frame_pkg::LINE_START;
            baud_cnt <= '0;
          end
          else
          begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            if (hunt_timeout)
              state <= ST_RESP;
            else if (bit_end)
              bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ST_RECV:
        begin
          baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
          if (mid_bit)
          begin
            case (phase)
              uart_frame_pkg::LINE_START:
              begin
                phase   <= uart_frame_pkg::LINE_DATA;
                bit_cnt <= '0;
              end
              uart_frame_pkg::LINE_DATA:
              begin
                if (bit_cnt == DATA_LAST)
                  phase <= uart_frame_pkg::LINE_PARITY;
                else
                  bit_cnt <= bit_cnt + 1'b1;
              end
              uart_frame_pkg::LINE_PARITY:
                phase <= uart_frame_pkg::LINE_STOP;
              default:
              begin
                phase <= uart_frame_pkg::LINE_IDLE;
                state <= ST_RESP;
              end
            endcase
          end
        end
        ST_RESP:
        begin
          if (ack)
            state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Receive path and held payload
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      tx_byte <= {cmd.wr.op, cmd.wr.chan, cmd.wr.reg_addr};
      wr_data <= cmd.wr.data;
      is_read <= cmd.rd.op == uart_cmd_pkg::RW_READ;
    end
    else if (gap_done)
    begin
      tx_byte <= wr_data;
    end

    if (data_sample)
      rx_shift <= {rx_sync, rx_shift[7:1]};
    if (parity_sample)
      par_bad <= rx_sync != uart_frame_pkg::frame_parity(rx_shift);

    if (stop_sample)
    begin
      resp_data <= rx_shift;
      resp_err  <= par_bad || !rx_sync;  // Low stop bit is a framing error
    end
    else if (hunt_timeout)
    begin
      resp_data <= '0;
      resp_err  <= 1'b1;
    end
  end

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n) start |-> !busy
  );

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n) (phase == uart_frame_pkg::LINE_IDLE) |-> tx
  );

endmodule

// ==== uart_cmd_dispatch.sv ====
`timescale 1ns/1ps
`include "uart_cmd_config.svh"

module uart_cmd_dispatch (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::cmd_word_u    cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  input  logic [`UART_NUM_CHAN-1:0]  busy,
  output logic [`UART_NUM_CHAN-1:0]  start,
  output uart_cmd_pkg::cmd_word_u    cmd
);

  logic                   hold_vld;
  logic                   issue;
  uart_cmd_pkg::chan_id_t target;

  assign cmd_rdy = !hold_vld;
  assign target  = cmd.wr.chan;
  assign issue   = hold_vld && !busy[target];  // Wait here while the target is busy

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hold_vld <= 1'b0;
    end
    else if (cmd_vld && cmd_rdy)
    begin
      hold_vld <= 1'b1;
    end
    else if (issue)
    begin
      hold_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd <= cmd_in;
    end
  end

  always_comb
  begin
    start = '0;
    if (issue)
    begin
      start[target] = 1'b1;
    end
  end

  a_start_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(start)
  );

endmodule

// ==== uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  typedef enum logic {
    RW_READ  = 1'b0,
    RW_WRITE = 1'b1
  } rw_e;

  typedef logic [1:0] chan_id_t;

  // Write view of a host command
  typedef struct packed {
    rw_e        op;
    chan_id_t   chan;
    logic [4:0] reg_addr;
    logic [7:0] data;
  } cmd_wr_t;

  // Read view, low byte carries nothing
  typedef struct packed {
    rw_e        op;
    chan_id_t   chan;
    logic [4:0] reg_addr;
    logic [7:0] rsvd;
  } cmd_rd_t;

  typedef union packed {
    cmd_wr_t wr;
    cmd_rd_t rd;
  } cmd_word_u;

endpackage

// ==== uart_frame_pkg.sv ====
package uart_frame_pkg;

  // Position inside one 11-bit serial frame
  typedef enum logic [2:0] {
    LINE_IDLE,
    LINE_START,
    LINE_DATA,
    LINE_PARITY,
    LINE_STOP
  } line_phase_e;

  // Odd parity, so the nine bits together hold an odd count of ones
  function automatic logic frame_parity(input logic [7:0] byte_val);
    return ~^byte_val;
  endfunction

endpackage

// ==== uart_cmd_config.svh ====
`ifndef UART_CMD_CONFIG_SVH
`define UART_CMD_CONFIG_SVH

// Clocks per serial bit, 434 for 115200 baud from 50 MHz
`define UART_BAUD_DIV          16

// Must match the 2-bit channel field of the command word
`define UART_NUM_CHAN          4

`define UART_GAP_BITS          2   // Idle bits between address and data frames
`define UART_RESP_TIMEOUT_BITS 40  // Bit times to wait for a response start bit

`endif
